// File: hw/dispatch_pkg.sv
package dispatch_pkg;

	// raw instruction word as delivered by the instruction queue
	typedef logic [31:0] instr_t;

	// register fields are cut to 3 bits, so the architectural file has 8 entries
	typedef logic [2:0] arch_reg_t;

	// reorder-buffer tag, wraps modulo 8
	typedef logic [2:0] rob_tag_t;

	// decoded operation class of one lane
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_mul = 2'd1,
		op_unsupported = 2'd2
	} op_class_e;

	// R-type major opcode
	localparam logic [6:0] OPCODE_OP = 7'b0110011;

	// funct7 selects add or multiply within the R-type group
	localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
	localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

	// both add and mul share funct3 zero
	localparam logic [2:0] FUNCT3_ADD_MUL = 3'b000;

	// entries per reservation station unless the top level overrides it
	localparam int RS_SLOTS_DEFAULT = 4;

endpackage

// File: hw/dispatch_lane_if.sv
`timescale 1ns/1ps

// one lane's view towards the arbiter
// lane keeps held, op and regs stable until it sees release_pulse
interface dispatch_lane_if;

	// lane holds a decoded instruction
	logic held;

	// decoded class of the held instruction
	dispatch_pkg::op_class_e op;

	// index 0 is rd, 1 is rs1, 2 is rs2
	dispatch_pkg::arch_reg_t [2:0] regs;

	// one-cycle pulse, held instruction is consumed
	logic release_pulse;

	modport lane (
		output held,
		output op,
		output regs,
		input release_pulse
	);

	modport arbiter (
		input held,
		input op,
		input regs,
		output release_pulse
	);

endinterface

// File: hw/dispatch_lane.sv
`timescale 1ns/1ps

module dispatch_lane (
	input logic clk,
	input logic reset,

	// request pulse towards the instruction queue
	output logic iq_read_en,

	// answer from the instruction queue
	input dispatch_pkg::instr_t instr,
	input logic instr_valid,

	dispatch_lane_if.lane lane
);

	// a read is in flight and not yet answered
	logic req_pending;

	// instruction hold register and its valid flag
	logic held_q;
	dispatch_pkg::instr_t instr_q;

	// fields of the held instruction
	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;

	// lane is empty now or becomes empty on this edge
	logic fetch_now;
	logic capture;

	assign capture = req_pending && instr_valid;
	assign fetch_now = !req_pending && (!held_q || lane.release_pulse);

	// request and hold control
	always_ff @(posedge clk) begin
		if (reset) begin
			iq_read_en <= 1'b0;
			req_pending <= 1'b0;
			held_q <= 1'b0;
		end else begin
			iq_read_en <= 1'b0;
			// only one request outstanding at a time
			if (fetch_now) begin
				iq_read_en <= 1'b1;
				req_pending <= 1'b1;
			end
			if (capture) begin
				req_pending <= 1'b0;
				held_q <= 1'b1;
			end else if (lane.release_pulse) begin
				held_q <= 1'b0;
			end
		end
	end

	// payload only, qualified by held_q
	always_ff @(posedge clk) begin
		if (capture) begin
			instr_q <= instr;
		end
	end

	assign opcode = instr_q[6:0];
	assign funct3 = instr_q[14:12];
	assign funct7 = instr_q[31:25];

	// decode into add, mul or unsupported
	always_comb begin
		lane.op = dispatch_pkg::op_unsupported;
		if (opcode == dispatch_pkg::OPCODE_OP && funct3 == dispatch_pkg::FUNCT3_ADD_MUL) begin
			if (funct7 == dispatch_pkg::FUNCT7_ADD) begin
				lane.op = dispatch_pkg::op_add;
			end else if (funct7 == dispatch_pkg::FUNCT7_MUL) begin
				lane.op = dispatch_pkg::op_mul;
			end
		end
	end

	// low 3 bits of rd, rs1 and rs2
	assign lane.regs[0] = instr_q[9:7];
	assign lane.regs[1] = instr_q[17:15];
	assign lane.regs[2] = instr_q[22:20];
	assign lane.held = held_q;

	// a lane never asks for more while it still holds an instruction
	a_no_fetch_while_held: assert property (
		@(posedge clk) disable iff (reset) iq_read_en |-> !lane.held
	);

	// arbiter only releases what the lane actually holds
	a_release_only_held: assert property (
		@(posedge clk) disable iff (reset) lane.release_pulse |-> lane.held
	);

endmodule

// File: hw/rs_capacity_check.sv
`timescale 1ns/1ps

module rs_capacity_check #(
	parameter int RS_SLOTS = dispatch_pkg::RS_SLOTS_DEFAULT
) (
	// one bit per free entry
	input logic [RS_SLOTS-1:0] add_free,
	input logic [RS_SLOTS-1:0] mul_free,

	// classes of the two lanes
	input dispatch_pkg::op_class_e op_0,
	input dispatch_pkg::op_class_e op_1,

	output logic fits
);

	// wide enough to count every slot
	localparam int CNT_W = $clog2(RS_SLOTS + 1);

	logic [CNT_W-1:0] add_cnt;
	logic [CNT_W-1:0] mul_cnt;
	logic [CNT_W-1:0] add_need;
	logic [CNT_W-1:0] mul_need;
	logic any_unsupported;

	// population count of both masks
	always_comb begin
		add_cnt = '0;
		mul_cnt = '0;
		for (int i = 0; i < RS_SLOTS; i++) begin
			add_cnt = add_cnt + CNT_W'(add_free[i]);
			mul_cnt = mul_cnt + CNT_W'(mul_free[i]);
		end
	end

	// entries the pair needs in each station, 0 to 2
	always_comb begin
		add_need = CNT_W'(op_0 == dispatch_pkg::op_add) + CNT_W'(op_1 == dispatch_pkg::op_add);
		mul_need = CNT_W'(op_0 == dispatch_pkg::op_mul) + CNT_W'(op_1 == dispatch_pkg::op_mul);
	end

	assign any_unsupported = (op_0 == dispatch_pkg::op_unsupported) ||
		(op_1 == dispatch_pkg::op_unsupported);

	// covers add+add, mul+mul and the mixed pair in one compare
	assign fits = !any_unsupported && (add_cnt >= add_need) && (mul_cnt >= mul_need);

endmodule

// File: hw/dispatch_arbiter.sv
`timescale 1ns/1ps

module dispatch_arbiter (
	input logic clk,
	input logic reset,

	// lane 0 has priority and takes the ROB tail
	dispatch_lane_if.arbiter lane_0,
	dispatch_lane_if.arbiter lane_1,

	input logic fits,
	input logic rat_ready,
	input dispatch_pkg::rob_tag_t rob_tail,

	output logic dispatch_valid,
	output dispatch_pkg::arch_reg_t rd_0,
	output dispatch_pkg::arch_reg_t rd_1,
	output dispatch_pkg::arch_reg_t rs1_0,
	output dispatch_pkg::arch_reg_t rs1_1,
	output dispatch_pkg::arch_reg_t rs2_0,
	output dispatch_pkg::arch_reg_t rs2_1,
	output logic multiply_0,
	output logic multiply_1,
	output dispatch_pkg::rob_tag_t renamed_tag_0,
	output dispatch_pkg::rob_tag_t renamed_tag_1
);

	// held, not being released this cycle, and add or mul
	logic ok_0, ok_1;
	// held unsupported instruction that gets dropped
	logic bad_0, bad_1;
	// pair dispatch decision
	logic go;

	always_comb begin
		ok_0 = lane_0.held && !lane_0.release_pulse && lane_0.op != dispatch_pkg::op_unsupported;
		ok_1 = lane_1.held && !lane_1.release_pulse && lane_1.op != dispatch_pkg::op_unsupported;
		bad_0 = lane_0.held && !lane_0.release_pulse && lane_0.op == dispatch_pkg::op_unsupported;
		bad_1 = lane_1.held && !lane_1.release_pulse && lane_1.op == dispatch_pkg::op_unsupported;
		go = ok_0 && ok_1 && rat_ready && fits;
	end

	// strobe and release pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			dispatch_valid <= 1'b0;
			lane_0.release_pulse <= 1'b0;
			lane_1.release_pulse <= 1'b0;
		end else begin
			dispatch_valid <= go;
			// an unsupported lane is cleared alone while the other keeps its instruction
			lane_0.release_pulse <= go || bad_0;
			lane_1.release_pulse <= go || bad_1;
		end
	end

	// dispatched pair is valid while dispatch_valid is high
	always_ff @(posedge clk) begin
		if (go) begin
			rd_0 <= lane_0.regs[0];
			rs1_0 <= lane_0.regs[1];
			rs2_0 <= lane_0.regs[2];
			rd_1 <= lane_1.regs[0];
			rs1_1 <= lane_1.regs[1];
			rs2_1 <= lane_1.regs[2];
			multiply_0 <= lane_0.op == dispatch_pkg::op_mul;
			multiply_1 <= lane_1.op == dispatch_pkg::op_mul;
			// tail and tail + 1 wrap at 8
			renamed_tag_0 <= rob_tail;
			renamed_tag_1 <= rob_tail + dispatch_pkg::rob_tag_t'(1);
		end
	end

	// a pair goes out as a one-cycle strobe
	a_single_dispatch: assert property (
		@(posedge clk) disable iff (reset) dispatch_valid |=> !dispatch_valid
	);

endmodule

// File: hw/dual_dispatch.sv
`timescale 1ns/1ps

module dual_dispatch #(
	parameter int RS_SLOTS = dispatch_pkg::RS_SLOTS_DEFAULT
) (
	input logic clk,
	input logic reset,

	// instruction queue, lane 0
	output logic iq_read_en_0,
	input dispatch_pkg::instr_t instr_0,
	input logic instr_valid_0,

	// instruction queue, lane 1
	output logic iq_read_en_1,
	input dispatch_pkg::instr_t instr_1,
	input logic instr_valid_1,

	// free entries of the reservation stations
	input logic [RS_SLOTS-1:0] add_free,
	input logic [RS_SLOTS-1:0] mul_free,

	input logic rat_ready,
	input dispatch_pkg::rob_tag_t rob_tail,

	// towards the register alias table
	output logic dispatch_valid,
	output dispatch_pkg::arch_reg_t rd_0,
	output dispatch_pkg::arch_reg_t rs1_0,
	output dispatch_pkg::arch_reg_t rs2_0,
	output logic multiply_0,
	output dispatch_pkg::rob_tag_t renamed_tag_0,
	output dispatch_pkg::arch_reg_t rd_1,
	output dispatch_pkg::arch_reg_t rs1_1,
	output dispatch_pkg::arch_reg_t rs2_1,
	output logic multiply_1,
	output dispatch_pkg::rob_tag_t renamed_tag_1
);

	dispatch_lane_if lane_if_0 ();
	dispatch_lane_if lane_if_1 ();

	// room in the stations for the current pair
	logic fits;

	// priority lane
	dispatch_lane lane_0_i (
		.clk(clk),
		.reset(reset),
		.iq_read_en(iq_read_en_0),
		.instr(instr_0),
		.instr_valid(instr_valid_0),
		.lane(lane_if_0.lane)
	);

	dispatch_lane lane_1_i (
		.clk(clk),
		.reset(reset),
		.iq_read_en(iq_read_en_1),
		.instr(instr_1),
		.instr_valid(instr_valid_1),
		.lane(lane_if_1.lane)
	);

	rs_capacity_check #(
		.RS_SLOTS(RS_SLOTS)
	) capacity_i (
		.add_free(add_free),
		.mul_free(mul_free),
		.op_0(lane_if_0.op),
		.op_1(lane_if_1.op),
		.fits(fits)
	);

	dispatch_arbiter arbiter_i (
		.clk(clk),
		.reset(reset),
		.lane_0(lane_if_0.arbiter),
		.lane_1(lane_if_1.arbiter),
		.fits(fits),
		.rat_ready(rat_ready),
		.rob_tail(rob_tail),
		.dispatch_valid(dispatch_valid),
		.rd_0(rd_0),
		.rd_1(rd_1),
		.rs1_0(rs1_0),
		.rs1_1(rs1_1),
		.rs2_0(rs2_0),
		.rs2_1(rs2_1),
		.multiply_0(multiply_0),
		.multiply_1(multiply_1),
		.renamed_tag_0(renamed_tag_0),
		.renamed_tag_1(renamed_tag_1)
	);

endmodule

// File: verif/dual_dispatch_tb.sv
`timescale 1ns/1ps

module dual_dispatch_tb;

	localparam int RS_SLOTS = dispatch_pkg::RS_SLOTS_DEFAULT;
	// limit of every wait loop, in cycles
	localparam int WAIT_LIMIT = 60;
	// cycles watched while a pair must stay blocked
	localparam int BLOCK_WINDOW = 12;

	logic clk;
	logic reset;
	logic iq_read_en_0, iq_read_en_1;
	logic instr_valid_0, instr_valid_1;
	dispatch_pkg::instr_t instr_0, instr_1;
	logic [RS_SLOTS-1:0] add_free, mul_free;
	logic rat_ready;
	dispatch_pkg::rob_tag_t rob_tail;
	logic dispatch_valid;
	dispatch_pkg::arch_reg_t rd_0, rs1_0, rs2_0, rd_1, rs1_1, rs2_1;
	logic multiply_0, multiply_1;
	dispatch_pkg::rob_tag_t renamed_tag_0, renamed_tag_1;

	// instruction queue model, words waiting per lane
	dispatch_pkg::instr_t iq_0[$];
	dispatch_pkg::instr_t iq_1[$];
	// request seen and not yet answered, with its remaining delay
	logic [1:0] pending;
	int countdown[2];
	int req_count[2];
	int dispatch_count;
	logic [31:0] lfsr;
	// outputs captured on the last dispatch pulse
	logic [31:0] seen_rd[2], seen_rs1[2], seen_rs2[2], seen_mul[2], seen_tag[2];
	int test_errors;
	int pass_count;
	int fail_count;

	// all port names match the testbench signals
	dual_dispatch #(.RS_SLOTS(RS_SLOTS)) dual_dispatch_i (.*);

	always #5 clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// answer delay of 0 to 3 cycles, one LFSR step per bit
	task automatic draw_delay(output int d);
		lfsr = lfsr_next(lfsr);
		d = int'(lfsr[0]);
		lfsr = lfsr_next(lfsr);
		d = d * 2 + int'(lfsr[0]);
	endtask

	task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %0h actual %0h", what, expected, actual);
			test_errors++;
		end
	endtask

	// instruction queue side of one lane, run once per cycle
	task automatic serve_lane(input int n, input logic read_en, output logic deliver,
			output dispatch_pkg::instr_t word);
		deliver = 1'b0;
		word = '0;
		if (read_en) begin
			req_count[n]++;
			if (pending[n]) begin
				$display("lane %0d asked again before its last request was answered", n);
				test_errors++;
			end
			pending[n] = 1'b1;
			draw_delay(countdown[n]);
		end
		if (pending[n]) begin
			if (countdown[n] > 0) begin
				countdown[n]--;
			end else if (n == 0 && iq_0.size() > 0) begin
				word = iq_0.pop_front();
				deliver = 1'b1;
				pending[n] = 1'b0;
			end else if (n == 1 && iq_1.size() > 0) begin
				word = iq_1.pop_front();
				deliver = 1'b1;
				pending[n] = 1'b0;
			end
		end
	endtask

	// one clock: sample outputs 1 ns after the edge, then drive
	task automatic step();
		dispatch_pkg::instr_t word;
		@(posedge clk);
		#1;
		if (dispatch_valid) begin
			dispatch_count++;
			seen_rd[0] = 32'(rd_0);
			seen_rs1[0] = 32'(rs1_0);
			seen_rs2[0] = 32'(rs2_0);
			seen_mul[0] = 32'(multiply_0);
			seen_tag[0] = 32'(renamed_tag_0);
			seen_rd[1] = 32'(rd_1);
			seen_rs1[1] = 32'(rs1_1);
			seen_rs2[1] = 32'(rs2_1);
			seen_mul[1] = 32'(multiply_1);
			seen_tag[1] = 32'(renamed_tag_1);
		end
		serve_lane(0, iq_read_en_0, instr_valid_0, word);
		if (instr_valid_0) instr_0 = word;
		serve_lane(1, iq_read_en_1, instr_valid_1, word);
		if (instr_valid_1) instr_1 = word;
	endtask

	task automatic wait_dispatches(input string name, input int target, output bit ok);
		int cycles;
		cycles = 0;
		while (dispatch_count < target && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		ok = (dispatch_count >= target);
		if (!ok) $display("%s: no dispatch came within %0d cycles", name, WAIT_LIMIT);
	endtask

	task automatic wait_requests(input string name, input int t0, input int t1, output bit ok);
		int cycles;
		cycles = 0;
		while ((req_count[0] < t0 || req_count[1] < t1) && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		ok = (req_count[0] >= t0 && req_count[1] >= t1);
		if (!ok) $display("%s: lanes did not ask for instructions within %0d cycles", name,
			WAIT_LIMIT);
	endtask

	// register fields are the low 3 bits, multiply follows funct7
	task automatic check_lane(input string name, input int n, input dispatch_pkg::instr_t word,
			input int tag);
		check($sformatf("%s rd_%0d", name, n), 32'(word[9:7]), seen_rd[n]);
		check($sformatf("%s rs1_%0d", name, n), 32'(word[17:15]), seen_rs1[n]);
		check($sformatf("%s rs2_%0d", name, n), 32'(word[22:20]), seen_rs2[n]);
		check($sformatf("%s multiply_%0d", name, n), 32'(word[31:25] == 7'd1), seen_mul[n]);
		check($sformatf("%s renamed_tag_%0d", name, n), 32'(tag % 8), seen_tag[n]);
	endtask

	task automatic run_test(input string name, input dispatch_pkg::instr_t word_0,
			input dispatch_pkg::instr_t word_1, input logic [31:0] add_mask,
			input logic [31:0] mul_mask, input logic [31:0] tail, input int rat_low,
			input dispatch_pkg::instr_t replace, input int expect_go, output bit ok);
		int base_0;
		int base_1;
		int base_disp;
		int extra_1;
		base_0 = req_count[0];
		base_1 = req_count[1];
		base_disp = dispatch_count;
		// a replacement word means lane 1 starts with an unsupported one
		extra_1 = (replace != '0) ? 1 : 0;
		ok = 1'b1;
		add_free = add_mask[RS_SLOTS-1:0];
		mul_free = mul_mask[RS_SLOTS-1:0];
		rob_tail = tail[2:0];
		rat_ready = (rat_low == 0);
		iq_0.push_back(word_0);
		iq_1.push_back(word_1);
		if (extra_1 == 1) begin
			// lane 1 drops its word and fetches again, lane 0 stays quiet
			wait_requests(name, base_0, base_1 + 1, ok);
			check({name, " lane 0 requests"}, 32'(base_0), 32'(req_count[0]));
			check({name, " dispatches"}, 32'(base_disp), 32'(dispatch_count));
			iq_1.push_back(replace);
		end
		if (ok && rat_low > 0) begin
			repeat (rat_low) step();
			check({name, " dispatches while rat busy"}, 32'(base_disp), 32'(dispatch_count));
			rat_ready = 1'b1;
		end
		if (ok && expect_go == 0) begin
			repeat (BLOCK_WINDOW) step();
			check({name, " dispatches while full"}, 32'(base_disp), 32'(dispatch_count));
			add_free = '1;
			mul_free = '1;
		end
		if (ok) wait_dispatches(name, base_disp + 1, ok);
		if (ok) begin
			check_lane(name, 0, word_0, int'(tail[2:0]));
			check_lane(name, 1, (extra_1 == 1) ? replace : word_1, int'(tail[2:0]) + 1);
			// each lane fetches exactly once more after the dispatch
			wait_requests(name, base_0 + 1, base_1 + 1 + extra_1, ok);
		end
		if (ok) begin
			check({name, " lane 0 requests"}, 32'(base_0 + 1), 32'(req_count[0]));
			check({name, " lane 1 requests"}, 32'(base_1 + 1 + extra_1), 32'(req_count[1]));
			check({name, " dispatches"}, 32'(base_disp + 1), 32'(dispatch_count));
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		if (ok && test_errors == 0) begin
			pass_count++;
			$display("test %s: pass", name);
		end else begin
			fail_count++;
			$display("test %s: fail", name);
		end
	endtask

	initial begin
		int fd;
		int fields;
		int rat_low;
		int expect_go;
		string line;
		string name;
		logic [31:0] word_0, word_1, replace, add_mask, mul_mask, tail;
		bit ok;
		bit aborted;
		clk = 1'b0;
		reset = 1'b1;
		instr_0 = '0;
		instr_1 = '0;
		instr_valid_0 = 1'b0;
		instr_valid_1 = 1'b0;
		add_free = '1;
		mul_free = '1;
		rat_ready = 1'b1;
		rob_tail = '0;
		lfsr = 32'h5ee4;
		pending = '0;
		req_count = '{0, 0};
		countdown = '{0, 0};
		dispatch_count = 0;
		pass_count = 0;
		fail_count = 0;
		aborted = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		// one request per lane right after reset
		test_errors = 0;
		wait_requests("reset_fetch", 1, 1, ok);
		check("reset_fetch lane 0 requests", 32'd1, 32'(req_count[0]));
		check("reset_fetch lane 1 requests", 32'd1, 32'(req_count[1]));
		report_test("reset_fetch", ok);
		aborted = !ok;
		fd = $fopen("verif/dual_dispatch_stim.txt", "r");
		if (fd == 0) begin
			$display("the stimulus file verif/dual_dispatch_stim.txt could not be opened");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			if ($fgets(line, fd) == 0) continue;
			if (line.len() < 3 || line.getc(0) == "#") continue;
			test_errors = 0;
			fields = $sscanf(line, "%s %h %h %h %h %h %d %h %d", name, word_0, word_1,
				add_mask, mul_mask, tail, rat_low, replace, expect_go);
			if (fields != 9) begin
				$display("a stimulus line could not be read: %s", line);
				fail_count++;
				continue;
			end
			run_test(name, word_0, word_1, add_mask, mul_mask, tail, rat_low, replace,
				expect_go, ok);
			report_test(name, ok);
			// a timed-out wait leaves the lanes out of step, so the run stops
			aborted = !ok;
		end
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && !aborted) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verif/dual_dispatch_stim.txt
# name instr_0 instr_1 add_free mul_free rob_tail rat_low_cycles replacement expect_dispatch
# replacement 00000000 keeps lane 1, expect_dispatch 0 means blocked until all entries are free
add_mul_basic 002081b3 027302b3 f f 0 0 00000000 1
mul_add_wrap 027302b3 002081b3 f f 7 0 00000000 1
trunc_regs 00f48633 03488fb3 3 8 5 0 00000000 1
add_add_short 002081b3 003100b3 4 f 2 0 00000000 0
add_add_exact 002081b3 00f48633 c 0 3 0 00000000 1
mul_mul_short 02620133 027302b3 f 1 6 0 00000000 0
mul_mul_exact 03488fb3 02620133 0 6 7 0 00000000 1
mixed_no_mul 002081b3 027302b3 f 0 1 0 00000000 0
rat_stall 00f48633 02620133 f f 4 6 00000000 1
rat_stall_long 03488fb3 003100b3 f f 7 15 00000000 1
lane1_sub 002081b3 402081b3 f f 1 0 027302b3 1
lane1_addi 03488fb3 00108093 f f 6 0 00f48633 1
lane1_div 02620133 027342b3 f f 7 2 003100b3 1

// File: dual_dispatch.f
hw/dispatch_pkg.sv
hw/dispatch_lane_if.sv
hw/dispatch_lane.sv
hw/rs_capacity_check.sv
hw/dispatch_arbiter.sv
hw/dual_dispatch.sv
verif/dual_dispatch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dual dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f dual_dispatch.f \
	--top-module dual_dispatch_tb -Mdir "$BUILD_DIR" -o dual_dispatch_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/dual_dispatch_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides the result
if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
